// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and scan the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_sram_top \
  -f sources.f -Mdir obj_dir -o sim_axi_sram > build.log 2>&1 &&
  ./obj_dir/sim_axi_sram > sim.log 2>&1 ||
  { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Finished with errors" sim.log && { echo "Simulation reported errors"; exit 1; }
echo "Simulation passed"
exit 0

// ==== sources.f ====
verilog/axi_sram_pkg.sv
verilog/sram_array.sv
verilog/axi_sram_write_ctrl.sv
verilog/axi_sram_read_ctrl.sv
verilog/axi_sram_top.sv
verif/tb_axi_sram_top.sv

// ==== verif/tb_axi_sram_top.sv ====
// Self-checking testbench for the AXI4 SRAM slave; compiled from sources.f as the simulation top
`default_nettype none

module tb_axi_sram_top;
  import axi_sram_pkg::*;

  localparam int DEPTH   = 256;
  localparam int TIMEOUT = 5000;
  localparam int CH_AW   = 0;
  localparam int CH_W    = 1;
  localparam int CH_AR   = 2;

  logic      i_aclk;
  logic      i_arst_n;
  axi_addr_t i_aw;
  logic      i_awvalid;
  logic      o_awready;
  axi_w_t    i_w;
  logic      i_wvalid;
  logic      o_wready;
  axi_b_t    o_b;
  logic      o_bvalid;
  logic      i_bready;
  axi_addr_t i_ar;
  logic      i_arvalid;
  logic      o_arready;
  axi_r_t    o_r;
  logic      o_rvalid;
  logic      i_rready;

  logic [AXI_DATA_W-1:0] shadow [DEPTH];
  int                    errors;
  axi_addr_t             wr_hdr;
  axi_addr_t             rd_hdr;
  logic                  wr_active;
  logic                  rd_active;
  int                    rd_beat;
  logic                  stall_en;
  logic [31:0]           r_pat;
  logic [31:0]           b_pat;

  // Compare process state
  axi_r_t exp_r;
  axi_b_t exp_b;
  axi_r_t r_hold;
  axi_b_t b_hold;
  logic   r_stalled;
  logic   b_stalled;
  logic   lat_armed;
  int     lat_cnt;

  axi_sram_top #(
    .DEPTH_WORDS (DEPTH)
  ) i_dut (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_aw      (i_aw),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_w       (i_w),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_b       (o_b),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .i_ar      (i_ar),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_r       (o_r),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready)
  );

  always #5 i_aclk = ~i_aclk;

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic [AXI_DATA_W-1:0] fill_word(input int unsigned word);
    return {8{8'(word)}} ^ 64'h0f1e_2d3c_4b5a_6978;
  endfunction

  function automatic axi_r_t expected_r(input axi_addr_t hdr, input int beat);
    axi_r_t      e;
    int unsigned word;
    word   = ((hdr.addr >> BYTE_LSB) + beat) % DEPTH;
    e.id   = hdr.id;
    e.last = (beat == int'(hdr.len));
    if (hdr.burst == BURST_INCR) begin
      e.data = shadow[word];
      e.resp = RESP_OKAY;
    end else begin
      e.data = '0;
      e.resp = RESP_SLVERR;
    end
    return e;
  endfunction

  function automatic axi_b_t expected_b(input axi_addr_t hdr);
    axi_b_t e;
    e.id   = hdr.id;
    e.resp = (hdr.burst == BURST_INCR) ? RESP_OKAY : RESP_SLVERR;
    return e;
  endfunction

  task automatic report_value(input string name, input logic [127:0] exp,
                              input logic [127:0] act);
    errors++;
    $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
  endtask

  task automatic report_text(input string what);
    errors++;
    $display("Error at time %0t: %s", $time, what);
  endtask

  task automatic abort_run(input string why);
    errors++;
    $display("Timeout at time %0t: %s", $time, why);
    $display("Error count: %0d", errors);
    $display("Finished with errors");
    $finish;
  endtask

  // --------------------------------------------------------------------------
  // Back-pressure and compare
  // --------------------------------------------------------------------------
  always @(negedge i_aclk) begin
    if (stall_en) begin
      i_rready = r_pat[0];
      i_bready = b_pat[0];
      r_pat    = {r_pat[0], r_pat[31:1]};
      b_pat    = {b_pat[0], b_pat[31:1]};
    end else begin
      i_rready = 1'b1;
      i_bready = 1'b1;
    end
  end

  // Sees the values from just before each rising edge
  always @(posedge i_aclk) begin
    if (i_arst_n) begin
      if (r_stalled) begin
        if (!o_rvalid) report_text("o_rvalid dropped while an R beat was stalled");
        if (o_r !== r_hold) report_value("o_r", r_hold, o_r);
      end
      if (b_stalled) begin
        if (!o_bvalid) report_text("o_bvalid dropped while the B response was stalled");
        if (o_b !== b_hold) report_value("o_b", b_hold, o_b);
      end
      if (lat_armed) begin
        if (o_rvalid) begin
          if (lat_cnt != 2) report_value("o_rvalid latency", 2, lat_cnt);
          lat_armed = 1'b0;
        end else begin
          lat_cnt++;
        end
      end
      if (i_arvalid && o_arready) begin
        lat_armed = 1'b1;
        lat_cnt   = 0;
      end
      if (o_rvalid && i_rready) begin
        if (!rd_active) begin
          report_text("R beat arrived with no read burst open");
        end else begin
          exp_r = expected_r(rd_hdr, rd_beat);
          if (o_r.id !== exp_r.id) report_value("o_r.id", exp_r.id, o_r.id);
          if (o_r.data !== exp_r.data) report_value("o_r.data", exp_r.data, o_r.data);
          if (o_r.resp !== exp_r.resp) report_value("o_r.resp", exp_r.resp, o_r.resp);
          if (o_r.last !== exp_r.last) report_value("o_r.last", exp_r.last, o_r.last);
          rd_beat++;
          if (rd_beat == int'(rd_hdr.len) + 1) rd_active = 1'b0;
          if (!o_r.last) begin
            lat_armed = 1'b1;
            lat_cnt   = 0;
          end
        end
      end
      if (o_bvalid && i_bready) begin
        if (!wr_active) begin
          report_text("B response arrived with no write burst open");
        end else begin
          exp_b = expected_b(wr_hdr);
          if (o_b.id !== exp_b.id) report_value("o_b.id", exp_b.id, o_b.id);
          if (o_b.resp !== exp_b.resp) report_value("o_b.resp", exp_b.resp, o_b.resp);
          wr_active = 1'b0;
        end
      end
      r_stalled = o_rvalid && !i_rready;
      b_stalled = o_bvalid && !i_bready;
      r_hold    = o_r;
      b_hold    = o_b;
    end else begin
      r_stalled = 1'b0;
      b_stalled = 1'b0;
      lat_armed = 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------------------------------
  function automatic logic ready_of(input int ch);
    case (ch)
      CH_AW:   return o_awready;
      CH_W:    return o_wready;
      default: return o_arready;
    endcase
  endfunction

  // Ready only moves on rising edges, so it is steady here
  task automatic wait_ready(input int ch, input string name);
    int n;
    n = 0;
    while (!ready_of(ch)) begin
      @(negedge i_aclk);
      n++;
      if (n > TIMEOUT) abort_run({name, " never went high"});
    end
  endtask

  task automatic pick_stalls(input logic enable);
    @(posedge i_aclk);
    stall_en = enable;
    r_pat    = $urandom | 32'h1111_1111;
    b_pat    = $urandom | 32'h0101_0101;
  endtask

  // Mode 0 fill pattern, 1 random data, 2 random data and strobes
  task automatic write_burst(input logic [AXI_ID_W-1:0] id, input logic [31:0] addr,
                             input int beats, input logic [1:0] burst, input int mode);
    axi_addr_t             hdr;
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    int unsigned           word;
    int                    n;
    hdr       = '0;
    hdr.id    = id;
    hdr.addr  = addr;
    hdr.len   = AXI_LEN_W'(beats - 1);
    hdr.size  = 3'd3;
    hdr.burst = burst;
    @(negedge i_aclk);
    wr_hdr    = hdr;
    wr_active = 1'b1;
    i_aw      = hdr;
    i_awvalid = 1'b1;
    wait_ready(CH_AW, "o_awready");
    @(posedge i_aclk);
    @(negedge i_aclk);
    i_awvalid = 1'b0;
    for (int beat = 0; beat < beats; beat++) begin
      word = ((addr >> BYTE_LSB) + beat) % DEPTH;
      if (mode != 0 && ($urandom % 4) == 0) begin
        i_wvalid = 1'b0;
        @(negedge i_aclk);
      end
      data     = (mode == 0) ? fill_word(word) : {$urandom, $urandom};
      strb     = (mode == 2) ? AXI_STRB_W'($urandom) : '1;
      i_w.data = data;
      i_w.strb = strb;
      i_w.last = (beat == beats - 1);
      i_wvalid = 1'b1;
      if (burst == BURST_INCR) begin
        for (int b = 0; b < AXI_STRB_W; b++) begin
          if (strb[b]) shadow[word][b*8 +: 8] = data[b*8 +: 8];
        end
      end
      wait_ready(CH_W, "o_wready");
      @(posedge i_aclk);
      @(negedge i_aclk);
    end
    i_wvalid = 1'b0;
    n = 0;
    while (wr_active) begin
      @(negedge i_aclk);
      n++;
      if (n > TIMEOUT) abort_run("write response never arrived");
    end
  endtask

  task automatic read_burst(input logic [AXI_ID_W-1:0] id, input logic [31:0] addr,
                            input int beats, input logic [1:0] burst);
    axi_addr_t hdr;
    int        n;
    hdr       = '0;
    hdr.id    = id;
    hdr.addr  = addr;
    hdr.len   = AXI_LEN_W'(beats - 1);
    hdr.size  = 3'd3;
    hdr.burst = burst;
    @(negedge i_aclk);
    rd_hdr    = hdr;
    rd_beat   = 0;
    rd_active = 1'b1;
    i_ar      = hdr;
    i_arvalid = 1'b1;
    wait_ready(CH_AR, "o_arready");
    @(posedge i_aclk);
    @(negedge i_aclk);
    i_arvalid = 1'b0;
    n = 0;
    while (rd_active) begin
      @(negedge i_aclk);
      n++;
      if (n > TIMEOUT) abort_run("read burst did not deliver all of its beats");
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    int unsigned         addr;
    int                  beats;
    logic [AXI_ID_W-1:0] id;
    void'($urandom(32'h9f80_23f5));
    i_aclk    = 1'b0;
    i_arst_n  = 1'b0;
    i_aw      = '0;
    i_awvalid = 1'b0;
    i_w       = '0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b1;
    i_ar      = '0;
    i_arvalid = 1'b0;
    i_rready  = 1'b1;
    errors    = 0;
    wr_hdr    = '0;
    rd_hdr    = '0;
    wr_active = 1'b0;
    rd_active = 1'b0;
    rd_beat   = 0;
    stall_en  = 1'b0;
    r_pat     = '1;
    b_pat     = '1;
    r_hold    = '0;
    b_hold    = '0;
    r_stalled = 1'b0;
    b_stalled = 1'b0;
    lat_armed = 1'b0;
    lat_cnt   = 0;

    repeat (10) @(posedge i_aclk);
    @(negedge i_aclk);
    i_arst_n = 1'b1;
    @(negedge i_aclk);
    if (o_bvalid !== 1'b0) report_value("o_bvalid", 1'b0, o_bvalid);
    if (o_rvalid !== 1'b0) report_value("o_rvalid", 1'b0, o_rvalid);
    if (o_awready !== 1'b1) report_value("o_awready", 1'b1, o_awready);
    if (o_arready !== 1'b1) report_value("o_arready", 1'b1, o_arready);
    if (o_wready !== 1'b0) report_value("o_wready", 1'b0, o_wready);

    // Known contents in every word, then a full-depth read back
    write_burst(4'h0, 32'h0, DEPTH, BURST_INCR, 0);
    read_burst(4'h1, 32'h0, DEPTH, BURST_INCR);

    // INCR traffic, full strobes then partial, stalls after the first few
    for (int i = 0; i < 40; i++) begin
      pick_stalls(i >= 10);
      addr  = $urandom & 32'hffff_fff8;
      beats = 1 + ($urandom % 8);
      id    = AXI_ID_W'($urandom);
      write_burst(id, addr, beats, BURST_INCR, (i % 2) + 1);
      read_burst(~id, addr, beats, BURST_INCR);
    end

    // FIXED and WRAP answer SLVERR and leave memory alone
    for (int i = 0; i < 6; i++) begin
      pick_stalls(1'b1);
      addr  = $urandom & 32'hffff_fff8;
      beats = 1 + ($urandom % 8);
      id    = AXI_ID_W'($urandom);
      write_burst(id, addr, beats, (i % 2) ? BURST_WRAP : BURST_FIXED, 1);
      read_burst(id, addr, beats, BURST_INCR);
      read_burst(id + 1'b1, addr, beats, (i % 2) ? BURST_FIXED : BURST_WRAP);
    end

    // Bursts across the top of memory
    pick_stalls(1'b1);
    write_burst(4'h9, 32'(252 << BYTE_LSB), 8, BURST_INCR, 2);
    read_burst(4'ha, 32'(252 << BYTE_LSB), 8, BURST_INCR);
    read_burst(4'hb, 32'h0000_2800, 4, BURST_INCR);
    write_burst(4'hc, 32'hffff_fff0, 5, BURST_INCR, 1);
    read_burst(4'hd, 32'hffff_fff0, 5, BURST_INCR);

    repeat (5) @(negedge i_aclk);
    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/axi_sram_pkg.sv ====
// Shared AXI widths, codes and channel structs; imported by the SRAM slave RTL and its testbench
`default_nettype none

package axi_sram_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int AXI_ID_W   = 4;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_LEN_W  = 8;

  // Byte offset bits below the word index
  localparam int BYTE_LSB = 3;

  // --------------------------------------------------------------------------
  // Response and burst encodings
  // --------------------------------------------------------------------------
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;

  // --------------------------------------------------------------------------
  // Channel payloads
  // --------------------------------------------------------------------------

  // AW and AR share one layout
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_LEN_W-1:0]  len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_addr_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

endpackage

`default_nettype wire

// ==== verilog/axi_sram_read_ctrl.sv ====
// AXI read-channel controller; takes AR, fetches SRAM words beat by beat and returns R
`default_nettype none

module axi_sram_read_ctrl #(
  parameter int  DEPTH_WORDS = 1024,
  localparam int ADDR_W      = $clog2(DEPTH_WORDS)
) (
  input  logic                                i_aclk,
  input  logic                                i_arst_n,

  input  axi_sram_pkg::axi_addr_t             i_ar,
  input  logic                                i_arvalid,
  output logic                                o_arready,

  output axi_sram_pkg::axi_r_t                o_r,
  output logic                                o_rvalid,
  input  logic                                i_rready,

  output logic                                o_mem_re,
  output logic [ADDR_W-1:0]                   o_mem_addr,
  input  logic [axi_sram_pkg::AXI_DATA_W-1:0] i_mem_rdata
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_SEND
  } state_t;

  state_t               state;
  logic                 re_q;
  logic [AXI_LEN_W-1:0] beat_cnt;
  logic [AXI_LEN_W-1:0] len_q;
  logic [AXI_ID_W-1:0]  id_q;
  logic [ADDR_W-1:0]    raddr_q;
  logic                 err_q;
  axi_r_t               r_q;

  logic ar_fire;
  logic r_fire;

  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  // --------------------------------------------------------------------------
  // State machine
  // --------------------------------------------------------------------------
  // FETCH spends one cycle on the enable and one waiting for the array output
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= S_IDLE;
      re_q     <= 1'b0;
      beat_cnt <= '0;
    end else begin
      re_q <= 1'b0;
      case (state)
        S_IDLE: begin
          if (ar_fire) begin
            state    <= S_FETCH;
            re_q     <= 1'b1;
            beat_cnt <= '0;
          end
        end
        S_FETCH: begin
          if (!re_q) state <= S_SEND;
        end
        S_SEND: begin
          if (r_fire) begin
            if (r_q.last) begin
              state <= S_IDLE;
            end else begin
              state    <= S_FETCH;
              re_q     <= 1'b1;
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      id_q    <= i_ar.id;
      len_q   <= i_ar.len;
      err_q   <= (i_ar.burst != BURST_INCR);
      raddr_q <= i_ar.addr[BYTE_LSB +: ADDR_W];
    end else if (r_fire) begin
      raddr_q <= raddr_q + 1'b1;
    end
  end

  // R payload loads once per beat on the way into SEND
  always_ff @(posedge i_aclk) begin
    if (state == S_FETCH && !re_q) begin
      r_q.id   <= id_q;
      r_q.data <= err_q ? '0 : i_mem_rdata;
      r_q.resp <= err_q ? RESP_SLVERR : RESP_OKAY;
      r_q.last <= (beat_cnt == len_q);
    end
  end

  assign o_arready  = (state == S_IDLE);
  assign o_rvalid   = (state == S_SEND);
  assign o_r        = r_q;
  assign o_mem_re   = re_q;
  assign o_mem_addr = raddr_q;

  a_ar_hold: assert property (
    @(posedge i_aclk) disable iff (!i_arst_n)
    (i_arvalid && !o_arready) |=> (i_arvalid && $stable(i_ar))
  ) else $error("AR request changed before handshake");

endmodule

`default_nettype wire

// ==== verilog/axi_sram_top.sv ====
// AXI4 SRAM slave top level; connects write and read controllers to the shared SRAM array
`default_nettype none

module axi_sram_top #(
  parameter int  DEPTH_WORDS = 1024,
  localparam int ADDR_W      = $clog2(DEPTH_WORDS)
) (
  input  logic                    i_aclk,
  input  logic                    i_arst_n,

  input  axi_sram_pkg::axi_addr_t i_aw,
  input  logic                    i_awvalid,
  output logic                    o_awready,

  input  axi_sram_pkg::axi_w_t    i_w,
  input  logic                    i_wvalid,
  output logic                    o_wready,

  output axi_sram_pkg::axi_b_t    o_b,
  output logic                    o_bvalid,
  input  logic                    i_bready,

  input  axi_sram_pkg::axi_addr_t i_ar,
  input  logic                    i_arvalid,
  output logic                    o_arready,

  output axi_sram_pkg::axi_r_t    o_r,
  output logic                    o_rvalid,
  input  logic                    i_rready
);
  import axi_sram_pkg::*;

  logic                  mem_we;
  logic [ADDR_W-1:0]     mem_waddr;
  logic [AXI_DATA_W-1:0] mem_wdata;
  logic [AXI_STRB_W-1:0] mem_wstrb;
  logic                  mem_re;
  logic [ADDR_W-1:0]     mem_raddr;
  logic [AXI_DATA_W-1:0] mem_rdata;

  axi_sram_write_ctrl #(
    .DEPTH_WORDS (DEPTH_WORDS)
  ) u_write_ctrl (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_aw        (i_aw),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_w         (i_w),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .o_b         (o_b),
    .o_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .o_mem_we    (mem_we),
    .o_mem_addr  (mem_waddr),
    .o_mem_wdata (mem_wdata),
    .o_mem_strb  (mem_wstrb)
  );

  axi_sram_read_ctrl #(
    .DEPTH_WORDS (DEPTH_WORDS)
  ) u_read_ctrl (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_ar        (i_ar),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .o_r         (o_r),
    .o_rvalid    (o_rvalid),
    .i_rready    (i_rready),
    .o_mem_re    (mem_re),
    .o_mem_addr  (mem_raddr),
    .i_mem_rdata (mem_rdata)
  );

  sram_array #(
    .DEPTH_WORDS (DEPTH_WORDS)
  ) u_sram (
    .i_aclk      (i_aclk),
    .i_we        (mem_we),
    .i_waddr     (mem_waddr),
    .i_wdata     (mem_wdata),
    .i_wstrb     (mem_wstrb),
    .i_re        (mem_re),
    .i_raddr     (mem_raddr),
    .o_rdata     (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== verilog/axi_sram_write_ctrl.sv ====
// AXI write-channel controller; takes AW, writes W beats into the SRAM port and returns B
`default_nettype none

module axi_sram_write_ctrl #(
  parameter int  DEPTH_WORDS = 1024,
  localparam int ADDR_W      = $clog2(DEPTH_WORDS)
) (
  input  logic                              i_aclk,
  input  logic                              i_arst_n,

  input  axi_sram_pkg::axi_addr_t           i_aw,
  input  logic                              i_awvalid,
  output logic                              o_awready,

  input  axi_sram_pkg::axi_w_t              i_w,
  input  logic                              i_wvalid,
  output logic                              o_wready,

  output axi_sram_pkg::axi_b_t              o_b,
  output logic                              o_bvalid,
  input  logic                              i_bready,

  output logic                              o_mem_we,
  output logic [ADDR_W-1:0]                 o_mem_addr,
  output logic [axi_sram_pkg::AXI_DATA_W-1:0] o_mem_wdata,
  output logic [axi_sram_pkg::AXI_STRB_W-1:0] o_mem_strb
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_DATA,
    S_RESP
  } state_t;

  state_t               state;
  logic [AXI_LEN_W-1:0] beat_cnt;
  logic [AXI_LEN_W-1:0] len_q;
  logic [AXI_ID_W-1:0]  id_q;
  logic [ADDR_W-1:0]    waddr_q;
  logic                 err_q;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic last_beat;

  assign aw_fire   = i_awvalid & o_awready;
  assign w_fire    = i_wvalid & o_wready;
  assign b_fire    = o_bvalid & i_bready;
  assign last_beat = (beat_cnt == len_q);

  // --------------------------------------------------------------------------
  // State machine
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= S_IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (aw_fire) begin
            state    <= S_DATA;
            beat_cnt <= '0;
          end
        end
        S_DATA: begin
          if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) state <= S_RESP;
          end
        end
        S_RESP: begin
          if (b_fire) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Burst context, captured on AW and stepped per beat
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      id_q    <= i_aw.id;
      len_q   <= i_aw.len;
      err_q   <= (i_aw.burst != BURST_INCR);
      waddr_q <= i_aw.addr[BYTE_LSB +: ADDR_W];
    end else if (w_fire) begin
      waddr_q <= waddr_q + 1'b1;
    end
  end

  assign o_awready = (state == S_IDLE);
  assign o_wready  = (state == S_DATA);
  assign o_bvalid  = (state == S_RESP);
  assign o_b.id    = id_q;
  assign o_b.resp  = err_q ? RESP_SLVERR : RESP_OKAY;

  // Error bursts never reach the array
  assign o_mem_we    = w_fire & ~err_q;
  assign o_mem_addr  = waddr_q;
  assign o_mem_wdata = i_w.data;
  assign o_mem_strb  = i_w.strb;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  a_wlast_match: assert property (
    @(posedge i_aclk) disable iff (!i_arst_n)
    w_fire |-> (i_w.last == last_beat)
  ) else $error("wlast does not match the burst length");

  a_aw_hold: assert property (
    @(posedge i_aclk) disable iff (!i_arst_n)
    (i_awvalid && !o_awready) |=> (i_awvalid && $stable(i_aw))
  ) else $error("AW request changed before handshake");

endmodule

`default_nettype wire

// ==== verilog/sram_array.sv ====
// Dual-port synchronous SRAM with byte strobes and a registered read port, behind the AXI slave
`default_nettype none

module sram_array #(
  parameter int  DEPTH_WORDS = 1024,
  localparam int ADDR_W      = $clog2(DEPTH_WORDS)
) (
  input  logic                                i_aclk,

  // Write port
  input  logic                                i_we,
  input  logic [ADDR_W-1:0]                   i_waddr,
  input  logic [axi_sram_pkg::AXI_DATA_W-1:0] i_wdata,
  input  logic [axi_sram_pkg::AXI_STRB_W-1:0] i_wstrb,

  // Read port
  input  logic                                i_re,
  input  logic [ADDR_W-1:0]                   i_raddr,
  output logic [axi_sram_pkg::AXI_DATA_W-1:0] o_rdata
);
  import axi_sram_pkg::*;

  logic [AXI_DATA_W-1:0] mem [DEPTH_WORDS];

  always_ff @(posedge i_aclk) begin
    if (i_we) begin
      for (int b = 0; b < AXI_STRB_W; b++) begin
        if (i_wstrb[b]) mem[i_waddr][b*8 +: 8] <= i_wdata[b*8 +: 8];
      end
    end
  end

  // Old data on a same-address collision
  always_ff @(posedge i_aclk) begin
    if (i_re) begin
      o_rdata <= mem[i_raddr];
    end
  end

endmodule

`default_nettype wire
